//--- vlog.f
logic/core_pkg.sv
logic/wb_intercon.sv
logic/misc_regs.sv
logic/settings_bus.sv
logic/vita_time.sv
logic/readback_mux.sv
logic/ctrl_core.sv
verif/ctrl_core_tb.sv

//--- run.sh
#!/bin/sh
# build and run the control core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
   --top-module ctrl_core_tb -f vlog.f -o ctrl_core_sim

out=$(./obj_dir/ctrl_core_sim 2>&1) || true
echo "$out"

if echo "$out" | grep -qx "Verification passed"; then
   exit 0
else
   exit 1
fi

//--- verif/ctrl_core_tb.sv
`timescale 1ns/100ps
`default_nettype none

module ctrl_core_tb import core_pkg::*;
  ();

   localparam logic [SET_AW-1:0] TIME_BASE   = SR_TIME64;
   localparam logic [SET_AW-1:0] TEST32_ADDR = SR_REG_TEST32;
   localparam int TBL_MAX  = 64;
   localparam int ACK_WAIT = 8;     // cycles a slave gets to ack

   typedef enum logic [2:0] {
      OP_WRITE,
      OP_READ,
      OP_READ_NZ,                   // read and expect any nonzero value
      OP_PPS,
      OP_STATUS,                    // drive cgen status inputs from dat[2:0]
      OP_PINS                       // cgen outputs against exp[1:0]
   } op_e;

   logic             wb_clk;
   logic             wb_rst;
   logic [WB_AW-1:0] wb_adr;
   logic [WB_DW-1:0] wb_dat;
   logic             wb_we;
   logic             wb_stb;
   logic             wb_cyc;
   logic [WB_DW-1:0] wb_dat_o;
   logic             wb_ack_o;
   logic             cgen_st_status;
   logic             cgen_st_ld;
   logic             cgen_st_refmon;
   logic             cgen_sync_b_o;
   logic             cgen_ref_sel_o;
   logic             pps;

   // stimulus table
   op_e              tbl_op  [TBL_MAX];
   logic [WB_AW-1:0] tbl_adr [TBL_MAX];
   logic [WB_DW-1:0] tbl_dat [TBL_MAX];
   logic [WB_DW-1:0] tbl_exp [TBL_MAX];
   int               n_entries = 0;

   int seed          = 32'hbc50;
   int cycle_cnt     = 0;
   int timeout_limit = 40 * TBL_MAX;

   ctrl_core #(.TIME_BASE(TIME_BASE), .TEST32_ADDR(TEST32_ADDR)) dut_i
     (.wb_clk(wb_clk), .wb_rst(wb_rst),
      .wb_adr_i(wb_adr), .wb_dat_i(wb_dat), .wb_we_i(wb_we),
      .wb_stb_i(wb_stb), .wb_cyc_i(wb_cyc),
      .wb_dat_o(wb_dat_o), .wb_ack_o(wb_ack_o),
      .cgen_st_status_i(cgen_st_status), .cgen_st_ld_i(cgen_st_ld),
      .cgen_st_refmon_i(cgen_st_refmon),
      .cgen_sync_b_o(cgen_sync_b_o), .cgen_ref_sel_o(cgen_ref_sel_o),
      .pps_i(pps));

   always #5 wb_clk = ~wb_clk;

   // watchdog
   always @(posedge wb_clk)
   begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt > timeout_limit)
         fail_run("run timed out, table did not finish in time");
   end

   ////////////////////////////////////////////////////////////////////////////
   // reporting

   task automatic fail_run(input string msg);
      $display("%s", msg);
      $display("Verification failed");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [WB_DW-1:0] got,
                              input logic [WB_DW-1:0] exp);
      if (got !== exp)
         fail_run($sformatf("CHECK FAILED: %s got %h expected %h", name, got, exp));
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // wishbone master, called at posedge + 1

   task automatic bus_cycle(input logic [WB_AW-1:0] adr, input logic [WB_DW-1:0] wdat,
                            input logic we, output logic [WB_DW-1:0] rdat);
      int   waited;
      logic got_ack;
      waited  = 0;
      got_ack = 1'b0;
      rdat    = '0;
      wb_adr  = adr;
      wb_dat  = wdat;
      wb_we   = we;
      wb_stb  = 1'b1;
      wb_cyc  = 1'b1;
      while (!got_ack && waited < ACK_WAIT)
      begin
         @(negedge wb_clk);           // mid cycle, outputs settled
         if (wb_ack_o)
         begin
            got_ack = 1'b1;
            rdat    = wb_dat_o;
         end
         else
            waited++;
      end
      if (!got_ack)
         fail_run($sformatf("no ack from the bus for address %h", adr));
      @(posedge wb_clk);
      #1;
      wb_stb = 1'b0;                  // drop in the cycle after ack
      wb_cyc = 1'b0;
      wb_we  = 1'b0;
      @(posedge wb_clk);
      #1;
   endtask

   task automatic wb_write(input logic [WB_AW-1:0] adr, input logic [WB_DW-1:0] wdat);
      logic [WB_DW-1:0] unused;
      bus_cycle(adr, wdat, 1'b1, unused);
   endtask

   task automatic wb_read(input logic [WB_AW-1:0] adr, output logic [WB_DW-1:0] rdat);
      bus_cycle(adr, '0, 1'b0, rdat);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // address maps

   function automatic logic [WB_AW-1:0] misc_adr(input logic [6:0] off);
      return {4'd0, off};
   endfunction

   function automatic logic [WB_AW-1:0] set_adr(input logic [SET_AW-1:0] sa, input logic hi);
      return {1'b1, sa, hi, 1'b0};
   endfunction

   function automatic logic [WB_AW-1:0] rb_adr(input logic [3:0] word, input logic hi);
      return {4'd7, 1'b0, word, hi, 1'b0};
   endfunction

   function automatic void add_entry(input op_e op, input logic [WB_AW-1:0] adr,
                                     input logic [WB_DW-1:0] dat, input logic [WB_DW-1:0] exp);
      tbl_op[n_entries]  = op;
      tbl_adr[n_entries] = adr;
      tbl_dat[n_entries] = dat;
      tbl_exp[n_entries] = exp;
      n_entries++;
   endfunction

   // low half first, the high half fires the setting
   function automatic void add_setting(input logic [SET_AW-1:0] sa, input logic [31:0] val);
      add_entry(OP_WRITE, set_adr(sa, 1'b0), val[15:0], '0);
      add_entry(OP_WRITE, set_adr(sa, 1'b1), val[31:16], '0);
   endfunction

   function automatic void build_table(input logic [31:0] rnd32, input logic [15:0] rnd16);
      // reset values
      add_entry(OP_PINS, '0, '0, 16'h0003);
      add_entry(OP_READ, misc_adr(MISC_CGEN_CTRL), '0, 16'h0003);
      add_entry(OP_READ, misc_adr(7'd2), '0, 16'hBEEF);
      add_entry(OP_READ, misc_adr(7'd12), '0, 16'hBEEF);
      // misc registers
      add_entry(OP_WRITE, misc_adr(MISC_TEST), rnd16, '0);
      add_entry(OP_READ, misc_adr(MISC_TEST), '0, rnd16);
      add_entry(OP_WRITE, misc_adr(MISC_CGEN_CTRL), 16'h0001, '0);
      add_entry(OP_PINS, '0, '0, 16'h0001);
      add_entry(OP_READ, misc_adr(MISC_CGEN_CTRL), '0, 16'h0001);
      add_entry(OP_WRITE, misc_adr(MISC_CGEN_CTRL), 16'h0002, '0);
      add_entry(OP_PINS, '0, '0, 16'h0002);
      add_entry(OP_READ, misc_adr(MISC_CGEN_CTRL), '0, 16'h0002);
      add_entry(OP_STATUS, '0, 16'h0005, '0);
      add_entry(OP_READ, misc_adr(MISC_CGEN_ST), '0, 16'h0005);
      add_entry(OP_STATUS, '0, 16'h0002, '0);
      add_entry(OP_READ, misc_adr(MISC_CGEN_ST), '0, 16'h0002);
      // test32 setting and compat word
      add_setting(TEST32_ADDR, rnd32);
      add_entry(OP_READ, rb_adr(RB_TEST32, 1'b0), '0, rnd32[15:0]);
      add_entry(OP_READ, rb_adr(RB_TEST32, 1'b1), '0, rnd32[31:16]);
      add_entry(OP_READ, rb_adr(RB_COMPAT, 1'b0), '0, 16'h0001);
      add_entry(OP_READ, rb_adr(RB_COMPAT, 1'b1), '0, 16'h0008);
      add_entry(OP_READ, rb_adr(4'd5, 1'b0), '0, 16'h0000);   // unlisted word
      // immediate time load
      add_setting(TIME_BASE, 32'h0000_0012);
      add_setting(TIME_BASE + SET_AW'(1), 32'h0000_0000);
      add_entry(OP_READ, rb_adr(RB_TIME_HI, 1'b0), '0, 16'h0012);
      add_entry(OP_READ, rb_adr(RB_TIME_HI, 1'b1), '0, 16'h0000);
      add_entry(OP_READ_NZ, rb_adr(RB_TIME_LO, 1'b0), '0, '0);
      // pps latch
      add_entry(OP_PPS, '0, '0, '0);
      add_entry(OP_READ, rb_adr(RB_PPS_HI, 1'b0), '0, 16'h0012);
      add_entry(OP_READ, rb_adr(RB_PPS_HI, 1'b1), '0, 16'h0000);
      // armed load waits for the next pps
      add_setting(TIME_BASE, 32'h0000_0034);
      add_setting(TIME_BASE + SET_AW'(2), 32'h0000_0000);
      add_entry(OP_READ, rb_adr(RB_TIME_HI, 1'b0), '0, 16'h0012);
      add_entry(OP_PPS, '0, '0, '0);
      add_entry(OP_READ, rb_adr(RB_TIME_HI, 1'b0), '0, 16'h0034);
      add_entry(OP_READ, rb_adr(RB_TIME_HI, 1'b1), '0, 16'h0000);
      add_entry(OP_READ, rb_adr(RB_PPS_HI, 1'b0), '0, 16'h0012);
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // main sequence

   initial
   begin
      logic [WB_DW-1:0] rdata;
      logic [31:0]      rnd32;
      logic [31:0]      rnd_b;
      wb_clk         = 1'b0;
      wb_rst         = 1'b1;
      wb_adr         = '0;
      wb_dat         = '0;
      wb_we          = 1'b0;
      wb_stb         = 1'b0;
      wb_cyc         = 1'b0;
      cgen_st_status = 1'b0;
      cgen_st_ld     = 1'b0;
      cgen_st_refmon = 1'b0;
      pps            = 1'b0;

      rnd32 = $random(seed);
      rnd_b = $random(seed);
      build_table(rnd32, rnd_b[15:0]);
      timeout_limit = 40 * n_entries;

      repeat (3) @(posedge wb_clk);
      #1;
      wb_rst = 1'b0;

      for (int i = 0; i < n_entries; i++)
      begin
         case (tbl_op[i])
            OP_WRITE:
               wb_write(tbl_adr[i], tbl_dat[i]);
            OP_READ:
            begin
               wb_read(tbl_adr[i], rdata);
               check_value($sformatf("wb_dat_o at %h", tbl_adr[i]), rdata, tbl_exp[i]);
            end
            OP_READ_NZ:
            begin
               wb_read(tbl_adr[i], rdata);
               check_value($sformatf("wb_dat_o nonzero at %h", tbl_adr[i]),
                           {15'd0, rdata != 16'd0}, 16'h0001);
            end
            OP_PPS:
            begin
               pps = 1'b1;
               repeat (4) @(posedge wb_clk);
               #1;
               pps = 1'b0;
               repeat (4) @(posedge wb_clk);   // through the synchronizer
               #1;
            end
            OP_STATUS:
            begin
               cgen_st_status = tbl_dat[i][2];
               cgen_st_ld     = tbl_dat[i][1];
               cgen_st_refmon = tbl_dat[i][0];
               @(posedge wb_clk);
               #1;
            end
            default:                          // OP_PINS
            begin
               check_value("cgen_sync_b_o", {15'd0, cgen_sync_b_o}, {15'd0, tbl_exp[i][1]});
               check_value("cgen_ref_sel_o", {15'd0, cgen_ref_sel_o}, {15'd0, tbl_exp[i][0]});
            end
         endcase
      end

      $display("Verification passed");
      $finish;
   end

endmodule

`default_nettype wire

//--- logic/ctrl_core.sv
`timescale 1ns/100ps
`default_nettype none

module ctrl_core import core_pkg::*;
  #(
   parameter logic [SET_AW-1:0] TIME_BASE   = SR_TIME64,
   parameter logic [SET_AW-1:0] TEST32_ADDR = SR_REG_TEST32
   )
  (
   input  wire logic             wb_clk,
   input  wire logic             wb_rst,
   input  wire logic [WB_AW-1:0] wb_adr_i,
   input  wire logic [WB_DW-1:0] wb_dat_i,
   input  wire logic             wb_we_i,
   input  wire logic             wb_stb_i,
   input  wire logic             wb_cyc_i,
   output logic [WB_DW-1:0]      wb_dat_o,
   output logic                  wb_ack_o,
   input  wire logic             cgen_st_status_i,
   input  wire logic             cgen_st_ld_i,
   input  wire logic             cgen_st_refmon_i,
   output logic                  cgen_sync_b_o,
   output logic                  cgen_ref_sel_o,
   input  wire logic             pps_i
   );

   logic              misc_stb, rb_stb, set_wb_stb;
   logic [WB_DW-1:0]  misc_dat, rb_dat;
   logic              misc_ack, rb_ack, set_ack;
   logic              set_stb;     // settings strobe, one cycle
   logic [SET_AW-1:0] set_addr;
   logic [31:0]       set_data;
   logic [63:0]       vita_time, vita_time_pps;

   ////////////////////////////////////////////////////////////////////////////
   // single master decode

   wb_intercon intercon
     (.wb_adr_i(wb_adr_i), .wb_stb_i(wb_stb_i), .wb_cyc_i(wb_cyc_i),
      .wb_dat_o(wb_dat_o), .wb_ack_o(wb_ack_o),
      .misc_stb_o(misc_stb), .rb_stb_o(rb_stb), .set_stb_o(set_wb_stb),
      .misc_dat_i(misc_dat), .rb_dat_i(rb_dat),
      .misc_ack_i(misc_ack), .rb_ack_i(rb_ack), .set_ack_i(set_ack));

   // slave 0
   misc_regs misc
     (.wb_clk(wb_clk), .wb_rst(wb_rst), .stb_i(misc_stb), .we_i(wb_we_i),
      .adr_i(wb_adr_i[6:0]), .dat_i(wb_dat_i), .dat_o(misc_dat), .ack_o(misc_ack),
      .cgen_st_status_i(cgen_st_status_i), .cgen_st_ld_i(cgen_st_ld_i),
      .cgen_st_refmon_i(cgen_st_refmon_i),
      .cgen_sync_b_o(cgen_sync_b_o), .cgen_ref_sel_o(cgen_ref_sel_o));

   // slaves 8..15
   settings_bus settings
     (.wb_clk(wb_clk), .wb_rst(wb_rst), .stb_i(set_wb_stb), .we_i(wb_we_i),
      .adr_i(wb_adr_i), .dat_i(wb_dat_i), .ack_o(set_ack),
      .set_stb_o(set_stb), .set_addr_o(set_addr), .set_data_o(set_data));

   ////////////////////////////////////////////////////////////////////////////
   // settings consumers

   vita_time #(.BASE(TIME_BASE)) timekeeper
     (.wb_clk(wb_clk), .wb_rst(wb_rst),
      .set_stb_i(set_stb), .set_addr_i(set_addr), .set_data_i(set_data),
      .pps_i(pps_i), .vita_time_o(vita_time), .vita_time_pps_o(vita_time_pps));

   // slave 7
   readback_mux #(.TEST_ADDR(TEST32_ADDR)) readback
     (.wb_clk(wb_clk), .wb_rst(wb_rst), .stb_i(rb_stb), .adr_i(wb_adr_i),
      .dat_o(rb_dat), .ack_o(rb_ack),
      .set_stb_i(set_stb), .set_addr_i(set_addr), .set_data_i(set_data),
      .vita_time_i(vita_time), .vita_time_pps_i(vita_time_pps));

endmodule

`default_nettype wire

//--- logic/readback_mux.sv
`timescale 1ns/100ps
`default_nettype none

module readback_mux import core_pkg::*;
  #(
   parameter logic [SET_AW-1:0] TEST_ADDR = SR_REG_TEST32
   )
  (
   input  wire logic              wb_clk,
   input  wire logic              wb_rst,
   input  wire logic              stb_i,
   input  wire logic [WB_AW-1:0]  adr_i,
   output logic [WB_DW-1:0]       dat_o,
   output logic                   ack_o,
   input  wire logic              set_stb_i,
   input  wire logic [SET_AW-1:0] set_addr_i,
   input  wire logic [31:0]       set_data_i,
   input  wire logic [63:0]       vita_time_i,
   input  wire logic [63:0]       vita_time_pps_i
   );

   logic [31:0] reg_test32;
   logic [31:0] word;

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
         reg_test32 <= '0;
      else if (set_stb_i && set_addr_i == TEST_ADDR)
         reg_test32 <= set_data_i;
   end

   ////////////////////////////////////////////////////////////////////////////
   // 16 word table, bits 5..2 pick the word

   always_comb
   begin
      case (adr_i[5:2])
         RB_TIME_HI: word = vita_time_i[63:32];
         RB_TIME_LO: word = vita_time_i[31:0];
         RB_PPS_HI:  word = vita_time_pps_i[63:32];
         RB_PPS_LO:  word = vita_time_pps_i[31:0];
         RB_TEST32:  word = reg_test32;
         RB_COMPAT:  word = COMPAT_NUM;
         default:    word = '0;
      endcase
   end

   always_ff @(posedge wb_clk)
   begin
      dat_o <= adr_i[1] ? word[31:16] : word[15:0];   // bit 1 picks the half
   end

   // stb is still up in the cycle after ack, so ack must not repeat
   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
         ack_o <= 1'b0;
      else
         ack_o <= stb_i & ~ack_o;
   end

   // a read in progress keeps its strobe and address until the ack
   assert property (@(posedge wb_clk) disable iff (wb_rst)
                    stb_i && !ack_o |=> stb_i && $stable(adr_i))
      else $error("readback strobe or address changed before ack_o");

endmodule

`default_nettype wire

//--- logic/vita_time.sv
`timescale 1ns/100ps
`default_nettype none

module vita_time import core_pkg::*;
  #(
   parameter logic [SET_AW-1:0] BASE = SR_TIME64
   )
  (
   input  wire logic              wb_clk,
   input  wire logic              wb_rst,
   input  wire logic              set_stb_i,
   input  wire logic [SET_AW-1:0] set_addr_i,
   input  wire logic [31:0]       set_data_i,
   input  wire logic              pps_i,
   output logic [63:0]            vita_time_o,
   output logic [63:0]            vita_time_pps_o
   );

   localparam logic [SET_AW-1:0] ADDR_HI  = BASE;
   localparam logic [SET_AW-1:0] ADDR_LO  = BASE + SET_AW'(1);
   localparam logic [SET_AW-1:0] ADDR_ARM = BASE + SET_AW'(2);

   logic [31:0] pending_hi;
   logic        armed;
   logic        pps_meta;
   logic        pps_sync;
   logic        pps_last;
   logic        pps_edge;

   ////////////////////////////////////////////////////////////////////////////
   // pps input, async to wb_clk

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         pps_meta <= 1'b0;
         pps_sync <= 1'b0;
         pps_last <= 1'b0;
      end
      else
      begin
         pps_meta <= pps_i;
         pps_sync <= pps_meta;
         pps_last <= pps_sync;   // edge detect only
      end
   end

   assign pps_edge = pps_sync & ~pps_last;

   always_ff @(posedge wb_clk)
   begin
      if (set_stb_i && set_addr_i == ADDR_HI)
         pending_hi <= set_data_i;
   end

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
         armed <= 1'b0;
      else if (set_stb_i && set_addr_i == ADDR_ARM)
         armed <= 1'b1;
      else if (pps_edge)
         armed <= 1'b0;       // one shot
   end

   // an immediate load wins over an armed pps load
   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
         vita_time_o <= '0;
      else if (set_stb_i && set_addr_i == ADDR_LO)
         vita_time_o <= {pending_hi, set_data_i};
      else if (pps_edge && armed)
         vita_time_o <= {pending_hi, 32'd0};
      else
         vita_time_o <= vita_time_o + 64'd1;
   end

   // snapshot of time at each pps
   always_ff @(posedge wb_clk)
   begin
      if (pps_edge)
         vita_time_pps_o <= vita_time_o;
   end

endmodule

`default_nettype wire

//--- logic/settings_bus.sv
`timescale 1ns/100ps
`default_nettype none

module settings_bus import core_pkg::*;
  (
   input  wire logic             wb_clk,
   input  wire logic             wb_rst,
   input  wire logic             stb_i,
   input  wire logic             we_i,
   input  wire logic [WB_AW-1:0] adr_i,
   input  wire logic [WB_DW-1:0] dat_i,
   output logic                  ack_o,
   output logic                  set_stb_o,
   output logic [SET_AW-1:0]     set_addr_o,
   output logic [31:0]           set_data_o
   );

   logic [WB_DW-1:0] low_half;
   logic             wr_stb;

   assign wr_stb = stb_i & we_i;

   // reads are acked too, there is just nothing to return
   assign ack_o = stb_i;

   ////////////////////////////////////////////////////////////////////////////
   // little endian pairing, bit 1 low is the low half

   always_ff @(posedge wb_clk)
   begin
      if (wr_stb && !adr_i[1])
         low_half <= dat_i;
   end

   always_ff @(posedge wb_clk)
   begin
      if (wr_stb && adr_i[1])
      begin
         set_addr_o <= adr_i[SET_AW+1:2];
         set_data_o <= {dat_i, low_half};
      end
   end

   // strobe follows the high half write by one cycle
   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
         set_stb_o <= 1'b0;
      else
         set_stb_o <= wr_stb & adr_i[1];
   end

   // master drops stb after the combinational ack, so one write gives one pulse
   assert property (@(posedge wb_clk) disable iff (wb_rst) set_stb_o |=> !set_stb_o)
      else $error("set_stb_o held for two cycles");

endmodule

`default_nettype wire

//--- logic/misc_regs.sv
`timescale 1ns/100ps
`default_nettype none

module misc_regs import core_pkg::*;
  (
   input  wire logic             wb_clk,
   input  wire logic             wb_rst,
   input  wire logic             stb_i,
   input  wire logic             we_i,
   input  wire logic [6:0]       adr_i,
   input  wire logic [WB_DW-1:0] dat_i,
   output logic [WB_DW-1:0]      dat_o,
   output logic                  ack_o,
   input  wire logic             cgen_st_status_i,
   input  wire logic             cgen_st_ld_i,
   input  wire logic             cgen_st_refmon_i,
   output logic                  cgen_sync_b_o,
   output logic                  cgen_ref_sel_o
   );

   logic [WB_DW-1:0] reg_cgen_ctrl;
   logic [WB_DW-1:0] reg_test;

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         reg_cgen_ctrl <= WB_DW'(CGEN_CTRL_RESET);
         reg_test      <= '0;
      end
      else if (stb_i && we_i)
      begin
         case (adr_i)
            MISC_CGEN_CTRL: reg_cgen_ctrl <= dat_i;
            MISC_TEST:      reg_test      <= dat_i;
            default:        ;              // status and the rest are read only
         endcase
      end
   end

   assign cgen_sync_b_o  = reg_cgen_ctrl[1];
   assign cgen_ref_sel_o = reg_cgen_ctrl[0];

   always_comb
   begin
      case (adr_i)
         MISC_CGEN_CTRL: dat_o = reg_cgen_ctrl;
         MISC_CGEN_ST:   dat_o = {13'd0, cgen_st_status_i, cgen_st_ld_i, cgen_st_refmon_i};
         MISC_TEST:      dat_o = reg_test;
         default:        dat_o = MISC_DEFAULT;
      endcase
   end

   assign ack_o = stb_i;   // zero wait states

endmodule

`default_nettype wire

//--- logic/wb_intercon.sv
`timescale 1ns/100ps
`default_nettype none

module wb_intercon import core_pkg::*;
  (
   input  wire logic [WB_AW-1:0] wb_adr_i,
   input  wire logic             wb_stb_i,
   input  wire logic             wb_cyc_i,
   output logic [WB_DW-1:0]      wb_dat_o,
   output logic                  wb_ack_o,
   output logic                  misc_stb_o,
   output logic                  rb_stb_o,
   output logic                  set_stb_o,
   input  wire logic [WB_DW-1:0] misc_dat_i,
   input  wire logic [WB_DW-1:0] rb_dat_i,
   input  wire logic             misc_ack_i,
   input  wire logic             rb_ack_i,
   input  wire logic             set_ack_i
   );

   slave_e slave;
   logic   bus_stb;

   // top four address bits pick the slave
   always_comb
   begin
      case (wb_adr_i[WB_AW-1 -: 4])
         4'd0:    slave = SLV_MISC;
         4'd7:    slave = SLV_READBACK;
         default: slave = wb_adr_i[WB_AW-1] ? SLV_SETTINGS : SLV_NONE;
      endcase
   end

   assign bus_stb    = wb_stb_i & wb_cyc_i;
   assign misc_stb_o = bus_stb & (slave == SLV_MISC);
   assign rb_stb_o   = bus_stb & (slave == SLV_READBACK);
   assign set_stb_o  = bus_stb & (slave == SLV_SETTINGS);

   always_comb
   begin
      case (slave)
         SLV_MISC:
         begin
            wb_dat_o = misc_dat_i;
            wb_ack_o = misc_ack_i;
         end
         SLV_READBACK:
         begin
            wb_dat_o = rb_dat_i;
            wb_ack_o = rb_ack_i;
         end
         SLV_SETTINGS:
         begin
            wb_dat_o = '0;         // write-only slave
            wb_ack_o = set_ack_i;
         end
         default:
         begin
            wb_dat_o = '0;
            wb_ack_o = 1'b0;       // unused slaves hang the master
         end
      endcase
   end

   // slaves must not ack a cycle the master is not running
   always_comb
   begin
      if (wb_ack_o)
         assert (wb_stb_i && wb_cyc_i)
         else $error("wb_ack_o high without wb_stb_i and wb_cyc_i");
   end

endmodule

`default_nettype wire

//--- logic/core_pkg.sv
`default_nettype none

package core_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // bus widths

   localparam int WB_DW  = 16;    // wishbone data
   localparam int WB_AW  = 11;    // wishbone byte address
   localparam int SET_AW = 8;     // settings register address

   ////////////////////////////////////////////////////////////////////////////
   // slave decode on address bits 10..7

   typedef enum logic [3:0] {
      SLV_MISC     = 4'd0,
      SLV_NONE     = 4'd1,        // any code without a slave behind it
      SLV_READBACK = 4'd7,
      SLV_SETTINGS = 4'd8         // codes 8..15 all land here
   } slave_e;

   // misc register offsets, address bits 6..0
   typedef enum logic [6:0] {
      MISC_CGEN_CTRL = 7'd4,
      MISC_CGEN_ST   = 7'd6,
      MISC_TEST      = 7'd8
   } misc_reg_e;

   localparam logic [WB_DW-1:0] MISC_DEFAULT    = 16'hBEEF;
   localparam logic [1:0]       CGEN_CTRL_RESET = 2'b11;   // sync_b and ref_sel high

   ////////////////////////////////////////////////////////////////////////////
   // settings map

   localparam logic [SET_AW-1:0] SR_TIME64     = 8'd42;   // +0 hi, +1 lo/load, +2 arm
   localparam logic [SET_AW-1:0] SR_REG_TEST32 = 8'd60;

   // bump when the register map changes
   localparam logic [31:0] COMPAT_NUM = {16'd8, 16'd1};   // major, minor

   // readback word indices
   localparam logic [3:0] RB_TIME_HI = 4'd0;
   localparam logic [3:0] RB_TIME_LO = 4'd1;
   localparam logic [3:0] RB_PPS_HI  = 4'd2;
   localparam logic [3:0] RB_PPS_LO  = 4'd3;
   localparam logic [3:0] RB_TEST32  = 4'd4;
   localparam logic [3:0] RB_COMPAT  = 4'd6;

endpackage

`default_nettype wire
